// File: tb.f
+incdir+hw
hw/router_pkg.sv
hw/next_tile_fifo_arb.sv
hw/router_fifo.sv
hw/router_out_arb.sv
hw/router.sv
hw/mini_core_tile.sv
sim/tile_checker.sv
sim/tile_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tile testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tile_tb -f tb.f -o tile_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tile_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
else
    echo "simulation did not pass, see $LOG"
    exit 1
fi

// File: sim/tile_tb.sv
// tile id 22 only; random destinations never point back out of the port they arrive on
`timescale 1ns/1ns
`default_nettype none

module tile_tb;
import router_pkg::*;

localparam int       N_TRANS = 400;
localparam int       MAX_CYC = N_TRANS * 20; // timeout
localparam t_tile_id TILE_ID = 8'h22;

logic        clk = 1'b0;
logic        rst;
logic        report;
int          errors;
int          outstanding;
t_tile_id    local_tile_id;
logic        in_north_req_valid, in_east_req_valid, in_south_req_valid, in_west_req_valid;
t_tile_trans in_north_req, in_east_req, in_south_req, in_west_req;
t_fab_ready  out_north_ready, out_east_ready, out_south_ready, out_west_ready;
logic        out_north_req_valid, out_east_req_valid, out_south_req_valid, out_west_req_valid;
t_tile_trans out_north_req, out_east_req, out_south_req, out_west_req;
t_fab_ready  in_north_ready, in_east_ready, in_south_ready, in_west_ready;
logic        core_req_valid;
t_tile_trans core_req;
t_cardinal   core_req_dir;
t_fab_ready  core_ready;
logic        core_rsp_valid;
t_tile_trans core_rsp;
logic        core_rsp_ready;

// driver state per port by t_cardinal value (local is the core)
t_tile_trans cur [5];
t_cardinal   dir [5]; // expected tag at this tile
int          seq [5];
logic [4:0]  pend;    // transaction waiting for its ready bit
int          gen_cnt;

assign local_tile_id = TILE_ID;

always #20 clk = ~clk; // 40 ns period

mini_core_tile dut_i (.*);
tile_checker   chk_i (.*);

// each bit high 3 times in 4
function automatic t_fab_ready rand_ready();
    return t_fab_ready'(5'($urandom) | 5'($urandom));
endfunction

task automatic new_trans(int p);
    t_tile_id  dest;
    t_cardinal d;
    d = t_cardinal'(p);
    while (d == t_cardinal'(p)) begin // u-turn has no fifo
        dest = {4'($urandom_range(0, 4)), 4'($urandom_range(0, 4))};
        d    = chk_i.route(TILE_ID, dest);
    end
    cur[p].address               = {dest, 24'($urandom)};
    cur[p].data                  = {8'(p), 24'(seq[p])}; // source then sequence
    cur[p].opcode                = t_opcode'($urandom_range(0, 2));
    cur[p].requestor_id          = 8'($urandom);
    cur[p].next_tile_fifo_arb_id = (p == 0) ? LOCAL : d; // dut tags the core itself
    dir[p]  = d;
    seq[p]  = seq[p] + 1;
    pend[p] = 1'b1;
    gen_cnt = gen_cnt + 1;
endtask

// called 2 ns after a rising edge
task automatic drive_cycle();
    t_fab_ready rdy [5];
    logic       v   [5];
    rdy = '{core_ready, out_north_ready, out_east_ready, out_south_ready, out_west_ready};
    for (int p = 0; p < 5; p++) begin
        v[p] = 1'b0;
        if (!pend[p] && gen_cnt < N_TRANS) new_trans(p);
        if (pend[p] && chk_i.ready_for(rdy[p], dir[p]) && $urandom_range(0, 2) != 0) begin
            v[p]    = 1'b1; // ready seen this cycle
            pend[p] = 1'b0;
        end
    end
    core_req_valid     = v[0];
    core_req           = cur[0];
    in_north_req_valid = v[1];
    in_north_req       = cur[1];
    in_east_req_valid  = v[2];
    in_east_req        = cur[2];
    in_south_req_valid = v[3];
    in_south_req       = cur[3];
    in_west_req_valid  = v[4];
    in_west_req        = cur[4];
    // neighbor back-pressure
    in_north_ready = rand_ready();
    in_east_ready  = rand_ready();
    in_south_ready = rand_ready();
    in_west_ready  = rand_ready();
    core_rsp_ready = ($urandom_range(0, 3) != 0);
endtask

initial begin : main
    int   cycles;
    logic timed_out;
    void'($urandom(58)); // seed once for the whole run
    cycles     = 0;
    timed_out  = 1'b0;
    rst        = 1'b1;
    report     = 1'b0;
    pend       = '0;
    gen_cnt    = 0;
    for (int p = 0; p < 5; p++) begin
        cur[p] = '0;
        dir[p] = LOCAL;
        seq[p] = 0;
    end
    core_req_valid     = 1'b0;
    core_req           = '0;
    core_rsp_ready     = 1'b1;
    in_north_req_valid = 1'b0;
    in_east_req_valid  = 1'b0;
    in_south_req_valid = 1'b0;
    in_west_req_valid  = 1'b0;
    in_north_req       = '0;
    in_east_req        = '0;
    in_south_req       = '0;
    in_west_req        = '0;
    in_north_ready     = '1;
    in_east_ready      = '1;
    in_south_ready     = '1;
    in_west_ready      = '1;

    repeat (8) @(posedge clk);
    #2 rst = 1'b0;

    // ==============================
    // traffic until drained
    // ==============================
    while (!timed_out && !(gen_cnt == N_TRANS && pend == '0 && outstanding == 0)) begin
        drive_cycle();
        @(posedge clk);
        #2;
        cycles = cycles + 1;
        if (cycles >= MAX_CYC) timed_out = 1'b1;
    end
    if (timed_out)
        $display("timeout after %0d cycles, %0d transactions still inside the tile",
                 cycles, outstanding);

    report = 1'b1; // checker prints its summary
    #1;
    if (errors == 0 && !timed_out) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: sim/tile_checker.sv
// samples at rising edges against an XY model; data[31:24] must hold the source port as the testbench sets it
`timescale 1ns/1ns
`default_nettype none
`include "router_cfg.svh"

module tile_checker (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         report,      // high at the end of the run
    output int                          errors,
    output int                          outstanding, // accepted but not yet out
    input  var router_pkg::t_tile_id    local_tile_id,
    input  wire                         in_north_req_valid, in_east_req_valid,
    input  wire                         in_south_req_valid, in_west_req_valid,
    input  var router_pkg::t_tile_trans in_north_req, in_east_req,
    input  var router_pkg::t_tile_trans in_south_req, in_west_req,
    input  var router_pkg::t_fab_ready  out_north_ready, out_east_ready,
    input  var router_pkg::t_fab_ready  out_south_ready, out_west_ready,
    input  wire                         out_north_req_valid, out_east_req_valid,
    input  wire                         out_south_req_valid, out_west_req_valid,
    input  var router_pkg::t_tile_trans out_north_req, out_east_req,
    input  var router_pkg::t_tile_trans out_south_req, out_west_req,
    input  var router_pkg::t_fab_ready  in_north_ready, in_east_ready,
    input  var router_pkg::t_fab_ready  in_south_ready, in_west_ready,
    input  wire                         core_req_valid,
    input  var router_pkg::t_tile_trans core_req,
    input  var router_pkg::t_cardinal   core_req_dir,
    input  var router_pkg::t_fab_ready  core_ready,
    input  wire                         core_rsp_valid,
    input  var router_pkg::t_tile_trans core_rsp,
    input  wire                         core_rsp_ready
);
import router_pkg::*;

t_tile_trans q [5][5][$];  // expected traffic per [source][output]
logic        in_v   [5];   // everything below indexed by t_cardinal value
t_tile_trans in_t   [5];
t_fab_ready  to_src [5];   // dut ready toward each sender
logic        out_v  [5];
t_tile_trans out_t  [5];
t_fab_ready  nbr    [5];   // neighbor ready seen by each output
string       pname  [5] = '{"local", "north", "east", "south", "west"};
logic        rst_q = 1'b1;
int          n_in  = 0;
int          n_out = 0;
int          n_err = 0;

assign errors      = n_err;
assign outstanding = n_in - n_out; // equals total queue depth

// ==============================
// model of the mesh rules
// ==============================

// X first then Y as decided at tile here
function automatic t_cardinal route(t_tile_id here, t_tile_id dest);
    logic [3:0] hx, hy, dx, dy;
    hx = here[`TILE_X_MSB:`TILE_X_LSB];
    hy = here[`TILE_Y_MSB:`TILE_Y_LSB];
    dx = dest[`TILE_X_MSB:`TILE_X_LSB];
    dy = dest[`TILE_Y_MSB:`TILE_Y_LSB];
    if (dx > hx) return EAST;
    if (dx < hx) return WEST;
    if (dy > hy) return SOUTH;
    if (dy < hy) return NORTH;
    return LOCAL;
endfunction

// tile one hop away where north is y-1
function automatic t_tile_id step(t_tile_id here, t_cardinal d);
    t_tile_id n;
    n = here;
    case (d)
        NORTH:   n[`TILE_Y_MSB:`TILE_Y_LSB] = here[`TILE_Y_MSB:`TILE_Y_LSB] - 4'd1;
        SOUTH:   n[`TILE_Y_MSB:`TILE_Y_LSB] = here[`TILE_Y_MSB:`TILE_Y_LSB] + 4'd1;
        EAST:    n[`TILE_X_MSB:`TILE_X_LSB] = here[`TILE_X_MSB:`TILE_X_LSB] + 4'd1;
        WEST:    n[`TILE_X_MSB:`TILE_X_LSB] = here[`TILE_X_MSB:`TILE_X_LSB] - 4'd1;
        default: ; // local stays put
    endcase
    return n;
endfunction

function automatic logic ready_for(t_fab_ready r, t_cardinal d);
    case (d)
        NORTH:   return r.north_arb;
        EAST:    return r.east_arb;
        SOUTH:   return r.south_arb;
        WEST:    return r.west_arb;
        default: return r.local_arb;
    endcase
endfunction

// idle ready struct with every fifo free but the u-turn one
function automatic t_fab_ready uturn_ready(t_cardinal d);
    t_fab_ready r;
    r = '1;
    case (d)
        NORTH:   r.north_arb = 1'b0;
        EAST:    r.east_arb  = 1'b0;
        SOUTH:   r.south_arb = 1'b0;
        WEST:    r.west_arb  = 1'b0;
        default: r.local_arb = 1'b0;
    endcase
    return r;
endfunction

always_comb begin : gather
    in_v   = '{core_req_valid, in_north_req_valid, in_east_req_valid,
               in_south_req_valid, in_west_req_valid};
    in_t   = '{core_req, in_north_req, in_east_req, in_south_req, in_west_req};
    to_src = '{core_ready, out_north_ready, out_east_ready, out_south_ready,
               out_west_ready};
    out_v  = '{core_rsp_valid, out_north_req_valid, out_east_req_valid,
               out_south_req_valid, out_west_req_valid};
    out_t  = '{core_rsp, out_north_req, out_east_req, out_south_req, out_west_req};
    nbr    = '{t_fab_ready'({5{core_rsp_ready}}), in_north_ready, in_east_ready,
               in_south_ready, in_west_ready}; // core sink has one ready
end

// ==============================
// reporting
// ==============================
task automatic report_value(string name, logic [79:0] got, logic [79:0] exp);
    $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    n_err++;
endtask

task automatic report_fail(string msg);
    $display("at %0t ns: %s", $time, msg);
    n_err++;
endtask

task automatic check_reset();
    for (int d = 0; d < 5; d++) begin
        if (out_v[d])
            report_fail($sformatf("output %s is valid right after reset", pname[d]));
        if (to_src[d] != uturn_ready(t_cardinal'(d)))
            report_value($sformatf("out_%s_ready", pname[d]), 80'(to_src[d]),
                         80'(uturn_ready(t_cardinal'(d))));
    end
endtask

// one transfer into the tile
task automatic accept(int s);
    t_cardinal exp_dir;
    exp_dir = route(local_tile_id, in_t[s].address[31:24]);
    if (!ready_for(to_src[s], exp_dir))
        report_fail($sformatf("input %s sent while its ready bit was low", pname[s]));
    q[s][exp_dir].push_back(in_t[s]);
    n_in++;
endtask

// one transfer out of the tile
task automatic check_out(int o);
    t_tile_trans got;
    t_tile_trans exp;
    int          src;
    got = out_t[o];
    src = int'(got.data[31:24]);
    if (src > 4) begin
        report_fail($sformatf("output %s sent data %h from no known source", pname[o],
                              got.data));
    end else if (q[src][o].size() == 0) begin
        report_fail($sformatf("output %s sent a transaction from %s that should not be there",
                              pname[o], pname[src]));
    end else begin
        exp = q[src][o].pop_front();
        exp.next_tile_fifo_arb_id = route(step(local_tile_id, t_cardinal'(o)),
                                          exp.address[31:24]); // decision at the neighbor
        n_out++;
        if (got != exp)
            report_value($sformatf("out_%s_req", pname[o]), 80'(got), 80'(exp));
    end
    if (!ready_for(nbr[o], got.next_tile_fifo_arb_id))
        report_fail($sformatf("output %s valid while the neighbor ready bit was low",
                              pname[o]));
endtask

always @(posedge clk) begin : compare
    rst_q <= rst;
    if (!rst) begin
        if (rst_q) check_reset(); // first edge out of reset
        if (core_req_dir != route(local_tile_id, core_req.address[31:24]))
            report_value("core_req_dir", 80'(core_req_dir),
                         80'(route(local_tile_id, core_req.address[31:24])));
        for (int o = 0; o < 5; o++) begin
            if (out_v[o]) check_out(o);
        end
        for (int s = 0; s < 5; s++) begin
            if (in_v[s]) accept(s);
        end
    end
end

initial begin : summary
    int left;
    left = 0;
    wait (report);
    for (int s = 0; s < 5; s++) begin
        for (int o = 0; o < 5; o++) left += q[s][o].size();
    end
    if (left != 0)
        report_fail($sformatf("%0d transactions never left the tile", left));
    $display("checker: %0d accepted, %0d delivered, %0d errors", n_in, n_out, n_err);
end

endmodule

`default_nettype wire

// File: hw/mini_core_tile.sv
// core may raise core_req_valid only while core_ready has the core_req_dir bit set; it cannot target its own tile
`timescale 1ns/1ns
`default_nettype none

module mini_core_tile (
    input  wire                         clk,
    input  wire                         rst,
    input  var router_pkg::t_tile_id    local_tile_id,
    // ==============================
    // fabric
    input  wire                         in_north_req_valid,
    input  var router_pkg::t_tile_trans in_north_req,
    output router_pkg::t_fab_ready      out_north_ready,
    output logic                        out_north_req_valid,
    output router_pkg::t_tile_trans     out_north_req,
    input  var router_pkg::t_fab_ready  in_north_ready,
    input  wire                         in_east_req_valid,
    input  var router_pkg::t_tile_trans in_east_req,
    output router_pkg::t_fab_ready      out_east_ready,
    output logic                        out_east_req_valid,
    output router_pkg::t_tile_trans     out_east_req,
    input  var router_pkg::t_fab_ready  in_east_ready,
    input  wire                         in_south_req_valid,
    input  var router_pkg::t_tile_trans in_south_req,
    output router_pkg::t_fab_ready      out_south_ready,
    output logic                        out_south_req_valid,
    output router_pkg::t_tile_trans     out_south_req,
    input  var router_pkg::t_fab_ready  in_south_ready,
    input  wire                         in_west_req_valid,
    input  var router_pkg::t_tile_trans in_west_req,
    output router_pkg::t_fab_ready      out_west_ready,
    output logic                        out_west_req_valid,
    output router_pkg::t_tile_trans     out_west_req,
    input  var router_pkg::t_fab_ready  in_west_ready,
    // ==============================
    // core port
    input  wire                         core_req_valid,
    input  var router_pkg::t_tile_trans core_req,       // next id field ignored
    output router_pkg::t_cardinal       core_req_dir,   // tag this tile gives core_req
    output router_pkg::t_fab_ready      core_ready,
    output logic                        core_rsp_valid, // ejection
    output router_pkg::t_tile_trans     core_rsp,
    input  wire                         core_rsp_ready
);
import router_pkg::*;

t_tile_trans in_local_req;   // core_req with its tag
t_fab_ready  in_local_ready;

// own routing decision for the injection
next_tile_fifo_arb #(.NEXT_TILE_CARDINAL(LOCAL)) core_dir_i (
    .local_tile_id (local_tile_id),
    .req_dest_id   (core_req.address[31:24]),
    .next_card     (core_req_dir)
);

always_comb begin : tag_core_req
    in_local_req                       = core_req;
    in_local_req.next_tile_fifo_arb_id = core_req_dir;
end

// core sink has a single ready so every fifo slot sees it
assign in_local_ready = '{default: core_rsp_ready};

// fabric ports match by name
router router_i (
    .*,
    .in_local_req_valid  (core_req_valid),
    .in_local_req        (in_local_req),
    .out_local_ready     (core_ready),
    .out_local_req_valid (core_rsp_valid),
    .out_local_req       (core_rsp),
    .in_local_ready      (in_local_ready)
);

endmodule

`default_nettype wire

// File: hw/router.sv
// no u-turn fifos, so a transfer tagged back toward its own input is dropped
`timescale 1ns/1ns
`default_nettype none

module router (
    input  wire                         clk,
    input  wire                         rst,
    input  var router_pkg::t_tile_id    local_tile_id,
    // ==============================
    // north
    input  wire                         in_north_req_valid,
    input  var router_pkg::t_tile_trans in_north_req,
    output router_pkg::t_fab_ready      out_north_ready,
    output logic                        out_north_req_valid,
    output router_pkg::t_tile_trans     out_north_req,
    input  var router_pkg::t_fab_ready  in_north_ready,
    // ==============================
    // east
    input  wire                         in_east_req_valid,
    input  var router_pkg::t_tile_trans in_east_req,
    output router_pkg::t_fab_ready      out_east_ready,
    output logic                        out_east_req_valid,
    output router_pkg::t_tile_trans     out_east_req,
    input  var router_pkg::t_fab_ready  in_east_ready,
    // ==============================
    // south
    input  wire                         in_south_req_valid,
    input  var router_pkg::t_tile_trans in_south_req,
    output router_pkg::t_fab_ready      out_south_ready,
    output logic                        out_south_req_valid,
    output router_pkg::t_tile_trans     out_south_req,
    input  var router_pkg::t_fab_ready  in_south_ready,
    // ==============================
    // west
    input  wire                         in_west_req_valid,
    input  var router_pkg::t_tile_trans in_west_req,
    output router_pkg::t_fab_ready      out_west_ready,
    output logic                        out_west_req_valid,
    output router_pkg::t_tile_trans     out_west_req,
    input  var router_pkg::t_fab_ready  in_west_ready,
    // ==============================
    // local
    input  wire                         in_local_req_valid,
    input  var router_pkg::t_tile_trans in_local_req,
    output router_pkg::t_fab_ready      out_local_ready,
    output logic                        out_local_req_valid,
    output router_pkg::t_tile_trans     out_local_req,
    input  var router_pkg::t_fab_ready  in_local_ready
);
import router_pkg::*;

// all arrays indexed by t_cardinal value
logic        in_valid  [5];
t_tile_trans in_req    [5];
t_fab_ready  in_ready  [5];
t_fab_ready  out_ready [5];
logic        out_valid [5];
t_tile_trans out_req   [5];
logic        nf [5][5]; // not_full of fifo [input][output]

assign in_valid = '{in_local_req_valid, in_north_req_valid, in_east_req_valid,
                    in_south_req_valid, in_west_req_valid};
assign in_req   = '{in_local_req, in_north_req, in_east_req, in_south_req, in_west_req};
assign in_ready = '{in_local_ready, in_north_ready, in_east_ready, in_south_ready,
                    in_west_ready};

// ==============================
// fifo grid + output arbiters
// ==============================
for (genvar o = 0; o < 5; o++) begin : g_out
    logic [3:0]  src_valid;
    logic [3:0]  src_pop;
    t_tile_trans src_trans [4];

    for (genvar s = 0; s < 4; s++) begin : g_src
        localparam int I = (s < o) ? s : s + 1; // skip the u-turn input
        router_fifo fifo_i (
            .clk       (clk),
            .rst       (rst),
            .wr_en     (in_valid[I] && (in_req[I].next_tile_fifo_arb_id == t_cardinal'(o))),
            .wr_data   (in_req[I]),
            .rd_en     (src_pop[s]),
            .rd_data   (src_trans[s]),
            .not_empty (src_valid[s]),
            .not_full  (nf[I][o])
        );
    end

    router_out_arb #(.OUT_CARDINAL(t_cardinal'(o))) arb_i (
        .clk           (clk),
        .rst           (rst),
        .local_tile_id (local_tile_id),
        .src_valid     (src_valid),
        .src_trans     (src_trans),
        .src_pop       (src_pop),
        .out_req_valid (out_valid[o]),
        .out_req       (out_req[o]),
        .in_ready      (in_ready[o])
    );

    assign nf[o][o] = 1'b0; // u-turn bit stays low
end

// ready structs toward each sender
for (genvar i = 0; i < 5; i++) begin : g_rdy
    assign out_ready[i] = '{north_arb: nf[i][NORTH], east_arb: nf[i][EAST],
                            south_arb: nf[i][SOUTH], west_arb: nf[i][WEST],
                            local_arb: nf[i][LOCAL]};
end

assign out_north_ready     = out_ready[NORTH];
assign out_north_req_valid = out_valid[NORTH];
assign out_north_req       = out_req[NORTH];
assign out_east_ready      = out_ready[EAST];
assign out_east_req_valid  = out_valid[EAST];
assign out_east_req        = out_req[EAST];
assign out_south_ready     = out_ready[SOUTH];
assign out_south_req_valid = out_valid[SOUTH];
assign out_south_req       = out_req[SOUTH];
assign out_west_ready      = out_ready[WEST];
assign out_west_req_valid  = out_valid[WEST];
assign out_west_req        = out_req[WEST];
assign out_local_ready     = out_ready[LOCAL];
assign out_local_req_valid = out_valid[LOCAL];
assign out_local_req       = out_req[LOCAL];

endmodule

`default_nettype wire

// File: hw/router_out_arb.sv
// purely combinational grant; the pop takes effect at the next edge and only eligible heads compete
`timescale 1ns/1ns
`default_nettype none

module router_out_arb #(
    parameter router_pkg::t_cardinal OUT_CARDINAL = router_pkg::LOCAL
) (
    input  wire                         clk,
    input  wire                         rst,
    input  var router_pkg::t_tile_id    local_tile_id,
    input  wire [3:0]                   src_valid,     // fifo not_empty
    input  var router_pkg::t_tile_trans src_trans [4], // fifo heads
    output logic [3:0]                  src_pop,
    output logic                        out_req_valid,
    output router_pkg::t_tile_trans     out_req,
    input  var router_pkg::t_fab_ready  in_ready       // from the neighbor
);
import router_pkg::*;

t_cardinal  nxt_card [4]; // rewritten id per head
logic [3:0] eligible;
logic [1:0] rr_ptr;       // first source to look at
logic [1:0] cand;
logic [1:0] win_idx;
logic       win_found;

// neighbor ready bit for the fifo a head will land in
function automatic logic ready_of(t_fab_ready rdy, t_cardinal card);
    case (card)
        NORTH:   return rdy.north_arb;
        EAST:    return rdy.east_arb;
        SOUTH:   return rdy.south_arb;
        WEST:    return rdy.west_arb;
        default: return rdy.local_arb;
    endcase
endfunction

// direction that leads straight back into this tile
function automatic t_cardinal back_of(t_cardinal card);
    case (card)
        NORTH:   return SOUTH;
        EAST:    return WEST;
        SOUTH:   return NORTH;
        WEST:    return EAST;
        default: return LOCAL;
    endcase
endfunction

// ==============================
// next-tile id per head
// ==============================
for (genvar i = 0; i < 4; i++) begin : g_nxt
    next_tile_fifo_arb #(.NEXT_TILE_CARDINAL(OUT_CARDINAL)) nxt_i (
        .local_tile_id (local_tile_id),
        .req_dest_id   (src_trans[i].address[31:24]),
        .next_card     (nxt_card[i])
    );
    // a blocked head drops out so the others still move
    assign eligible[i] = src_valid[i] && ready_of(in_ready, nxt_card[i]);
end

// first eligible at or after rr_ptr
always_comb begin : rr_pick
    win_found = 1'b0;
    win_idx   = '0;
    cand      = '0;
    for (int k = 0; k < 4; k++) begin
        cand = rr_ptr + 2'(k);
        if (!win_found && eligible[cand]) begin
            win_found = 1'b1;
            win_idx   = cand;
        end
    end
end

assign out_req_valid = win_found;
assign src_pop       = win_found ? (4'b0001 << win_idx) : 4'b0000;

always_comb begin : rewrite
    out_req                       = src_trans[win_idx];
    out_req.next_tile_fifo_arb_id = nxt_card[win_idx]; // direction inside the neighbor
end

always_ff @(posedge clk) begin
    if (rst) begin
        rr_ptr <= '0;
    end else if (win_found) begin
        rr_ptr <= win_idx + 2'd1; // winner goes to the back
    end
end

// a head tagged right by its sender never turns back at the neighbor
a_no_bounce: assert property (@(posedge clk) disable iff (rst)
    out_req_valid |-> ((OUT_CARDINAL == LOCAL) ?
                       (out_req.next_tile_fifo_arb_id == LOCAL) :
                       (out_req.next_tile_fifo_arb_id != back_of(OUT_CARDINAL))))
    else $error("router_out_arb: head was steered to the wrong output");

endmodule

`default_nettype wire

// File: hw/router_fifo.sv
// depth must be a power of two; rd_data is only meaningful while not_empty is high
`timescale 1ns/1ns
`default_nettype none
`include "router_cfg.svh"

module router_fifo (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         wr_en,
    input  var router_pkg::t_tile_trans wr_data,
    input  wire                         rd_en,
    output router_pkg::t_tile_trans     rd_data,
    output logic                        not_empty,
    output logic                        not_full
);
import router_pkg::*;

localparam int DEPTH = `ROUTER_FIFO_DEPTH;
localparam int PW    = $clog2(DEPTH);

t_tile_trans   mem [DEPTH];
logic [PW-1:0] wr_ptr;
logic [PW-1:0] rd_ptr;
logic [PW:0]   count; // one extra bit to tell full from empty

always_ff @(posedge clk) begin
    if (rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
        if (rd_en) rd_ptr <= rd_ptr + 1'b1;
        case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ; // both or neither
        endcase
    end
end

// payload store
always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
end

assign rd_data   = mem[rd_ptr]; // head, visible the cycle after the write
assign not_empty = (count != '0);
assign not_full  = (count != DEPTH[PW:0]); // registered, feeds the sender's ready

// the upstream tile must have honored not_full from the previous edge
a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> not_full)
    else $error("router_fifo: write while full");
a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> not_empty)
    else $error("router_fifo: read while empty");

endmodule

`default_nettype wire

// File: hw/next_tile_fifo_arb.sv
// assumes the neighbor in NEXT_TILE_CARDINAL is on the mesh, so an edge tile trips the wrap check
`timescale 1ns/1ns
`default_nettype none
`include "router_cfg.svh"

module next_tile_fifo_arb #(
    parameter router_pkg::t_cardinal NEXT_TILE_CARDINAL = router_pkg::LOCAL
) (
    input  var router_pkg::t_tile_id  local_tile_id,
    input  var router_pkg::t_tile_id  req_dest_id,
    output router_pkg::t_cardinal     next_card
);
import router_pkg::*;

localparam int XW = `TILE_X_MSB - `TILE_X_LSB + 1;
localparam int YW = `TILE_Y_MSB - `TILE_Y_LSB + 1;

logic [XW-1:0] loc_x, dst_x, nbr_x;
logic [YW-1:0] loc_y, dst_y, nbr_y;
logic          nbr_wrap; // step left the 4-bit coordinate range

assign loc_x = local_tile_id[`TILE_X_MSB:`TILE_X_LSB];
assign loc_y = local_tile_id[`TILE_Y_MSB:`TILE_Y_LSB];
assign dst_x = req_dest_id[`TILE_X_MSB:`TILE_X_LSB];
assign dst_y = req_dest_id[`TILE_Y_MSB:`TILE_Y_LSB];

// ==============================
// neighbor one hop away
// ==============================
always_comb begin : nbr_step
    nbr_x    = loc_x;
    nbr_y    = loc_y;
    nbr_wrap = 1'b0;
    case (NEXT_TILE_CARDINAL)
        NORTH: begin
            nbr_y    = loc_y - 1'b1; // north is y-1
            nbr_wrap = (loc_y == '0);
        end
        SOUTH: {nbr_wrap, nbr_y} = {1'b0, loc_y} + 1'b1;
        EAST:  {nbr_wrap, nbr_x} = {1'b0, loc_x} + 1'b1;
        WEST: begin
            nbr_x    = loc_x - 1'b1;
            nbr_wrap = (loc_x == '0);
        end
        default: ; // LOCAL keeps own id
    endcase
    if (!$isunknown(local_tile_id)) begin
        a_no_wrap: assert (!nbr_wrap)
            else $error("next_tile_fifo_arb: neighbor of tile %h wraps", local_tile_id);
    end
end

// x first, then y, as seen from the neighbor
always_comb begin : xy_route
    if (dst_x > nbr_x)      next_card = EAST;
    else if (dst_x < nbr_x) next_card = WEST;
    else if (dst_y > nbr_y) next_card = SOUTH;
    else if (dst_y < nbr_y) next_card = NORTH;
    else                    next_card = LOCAL; // arrived
end

endmodule

`default_nettype wire

// File: hw/router_pkg.sv
// enum encodings are shared by every tile, so all tiles of one mesh must use the same package
`default_nettype none

package router_pkg;

    typedef logic [7:0] t_tile_id; // {x, y}

    // direction of travel, also selects the fifo in the next tile
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        NORTH = 3'd1,
        EAST  = 3'd2,
        SOUTH = 3'd3,
        WEST  = 3'd4
    } t_cardinal;

    typedef enum logic [1:0] {
        WR     = 2'd0,
        RD     = 2'd1,
        RD_RSP = 2'd2
    } t_opcode; // router never looks at it

    // one fabric transfer, 77 bits
    typedef struct packed {
        logic [31:0] address;               // [31:24] dest tile id
        logic [31:0] data;
        t_opcode     opcode;
        t_tile_id    requestor_id;
        t_cardinal   next_tile_fifo_arb_id; // fifo to use in the receiving tile
    } t_tile_trans;

    // one bit per receiving fifo, high when it has room
    typedef struct packed {
        logic north_arb;
        logic east_arb;
        logic south_arb;
        logic west_arb;
        logic local_arb;
    } t_fab_ready;

endpackage

`default_nettype wire

// File: hw/router_cfg.svh
// fifo depth must be a power of two; tile id is x in the high nibble and y in the low nibble
`ifndef ROUTER_CFG_SVH
`define ROUTER_CFG_SVH

// entries per input fifo
`define ROUTER_FIFO_DEPTH 4

// ==============================
// tile id fields
// ==============================
`define TILE_X_MSB 7
`define TILE_X_LSB 4
`define TILE_Y_MSB 3
`define TILE_Y_LSB 0

`endif
